// File: flist.f
board_pkg.sv
joy_serial_reader.sv
ps2_receiver.sv
key_decoder.sv
core_control.sv
board_ctrl_top.sv
tb_clock.sv
tb_board_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the board control testbench with Verilator and runs it.
# The run passes only if the log holds the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_board_ctrl \
  -f flist.f \
  -o tb_board_ctrl
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_board_ctrl > sim.log 2>&1
run_status=$?
cat sim.log

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "Everything OK" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation did not pass"
  exit 1
fi

// File: tb_board_ctrl.sv
/*
  Board control testbench
  Shift-register model, PS/2 keyboard sender, LFSR joystick stimulus,
  concurrent checks of every control output and a watchdog
*/
module tb_board_ctrl;
  import board_pkg::*;

  localparam int RAND_FRAMES  = 40;
  localparam int FIXED_FRAMES = 30;
  localparam int KEY_FRAMES   = 14;
  localparam int PS2_HALF     = 8;
  // One key frame is 11 slow PS/2 bits plus the settle time
  localparam int PS2_CYC      = 11 * (2 * PS2_HALF + 1) + 20;
  localparam int WATCH_CYC    = (RAND_FRAMES + FIXED_FRAMES) * 26 + KEY_FRAMES * PS2_CYC
                                + 2 * (POR_CYCLES + 16) + 500;

  logic        ena_x;
  logic        lock_gen;
  logic        relock_n = 1'b1;
  logic        pll_lckd;
  logic        joy_data = 1'b1;
  logic        ps2_clk = 1'b1;
  logic        ps2_data = 1'b1;
  logic [1:0]  btn = 2'b11;
  logic [7:0]  sram_data = 8'h00;
  logic        joy_load;
  logic [18:0] sram_addr;
  logic        sram_we_n;
  logic [1:0]  led;
  logic        core_reset;
  logic        game_reset;
  logic        reboot;
  logic [5:0]  joy_a;
  logic [5:0]  joy_b;
  logic [1:0]  player_n;
  logic [1:0]  coin_n;
  logic [1:0]  scandbl_ctrl;

  // Shift-register model and expected values
  logic [31:0] sr;
  logic [4:0]  bit_idx;
  logic [23:0] pat_prev;
  logic [23:0] fixed_pat = '1;
  logic [1:0]  fixed_btn = 2'b11;
  logic        joy_rand = 1'b1;
  logic [1:0]  exp_btn;
  joy_state_t  exp1;
  joy_state_t  exp2;
  int          loads;
  logic [15:0] lfsr = 16'd57;
  logic        exp_gr;
  logic        exp_reboot;
  logic        chord_sent = 1'b0;
  logic        exp_mode = 1'b0;
  logic        exp_swap = 1'b0;
  logic        key_busy = 1'b0;
  logic [1:0]  sd1;
  logic        sd2;
  int          lock_edges;
  int          gr_high;

  // Second reset for the reboot test
  assign pll_lckd = lock_gen & relock_n;

  tb_clock clk_gen (
    .ena_x (ena_x),
    .lock  (lock_gen)
  );

  board_ctrl_top dut (.*);

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR with x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // Serial order is start, fire3, fire2, fire1, right, left, down, up
  function automatic joy_state_t unpack_joy(input logic [7:0] grp, input logic [3:0] ext);
    joy_state_t j;
    j = {ext[1], ext[0], ext[2], grp[0], ext[3], grp[1], grp[2], grp[3],
         grp[4], grp[5], grp[6], grp[7]};
    return j;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("error t=%0t %s got %0h expected %0h", $time, name, got, want);
    $display("Something failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic fail_with(input string what);
    $display("%s at t=%0t", what, $time);
    $display("Something failed");
    $fatal(1, "check failed");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Joystick shift register, buttons and SRAM data
  //////////////////////////////////////////////////////////////////////

  always @(posedge ena_x or negedge pll_lckd) begin : joy_model
    logic [23:0] pat;
    logic [1:0]  nb;
    if (!pll_lckd) begin
      sr       <= '1;
      bit_idx  <= '0;
      pat_prev <= '1;
      exp1     <= '1;
      exp2     <= '1;
      exp_btn  <= 2'b11;
      loads    <= 0;
    end else begin
      if (!joy_load) begin
        if (joy_rand) begin
          for (int i = 0; i < 24; i++) begin
            lfsr = lfsr_step(lfsr);
            pat[i] = lfsr[0];
          end
          for (int i = 0; i < 2; i++) begin
            lfsr = lfsr_step(lfsr);
            nb[i] = lfsr[0];
          end
          // Joystick 2 select stays released so reboot is not latched
          pat[17] = 1'b1;
        end else begin
          pat = fixed_pat;
          nb  = fixed_btn;
        end
        sr       <= {8'hFF, pat};
        bit_idx  <= '0;
        btn      <= nb;
        exp_btn  <= nb;
        // Previous frame becomes visible at this load
        exp1     <= unpack_joy(pat_prev[7:0], pat_prev[23:20]);
        exp2     <= unpack_joy(pat_prev[15:8], pat_prev[19:16]);
        pat_prev <= pat;
        loads    <= loads + 1;
      end else begin
        joy_data <= sr[bit_idx];
        bit_idx  <= bit_idx + 1'b1;
      end
      lfsr = lfsr_step(lfsr);
      sram_data[0] <= lfsr[0];
      lfsr = lfsr_step(lfsr);
      sram_data[1] <= lfsr[0];
      sram_data[7:2] <= 6'b101101;
    end
  end

  // Expected registered outputs
  always @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      lock_edges <= 0;
      sd1        <= 2'b00;
      sd2        <= 1'b0;
      exp_gr     <= 1'b0;
      exp_reboot <= 1'b0;
      gr_high    <= 0;
    end else begin
      if (lock_edges < 1000)
        lock_edges <= lock_edges + 1;
      sd1        <= sram_data[1:0];
      sd2        <= sd1[0];
      exp_gr     <= ~exp1.sel_n | ~btn[1];
      exp_reboot <= exp_reboot | ~exp2.sel_n | chord_sent;
      if (!key_busy)
        gr_high <= 0;
      else if (game_reset)
        gr_high <= gr_high + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  a_reset_state : assert property (@(posedge ena_x) !pll_lckd |->
    (core_reset && !game_reset && !reboot && led == 2'b00 && scandbl_ctrl == 2'b00
     && joy_load))
    else fail_with("control outputs not inactive during reset");
  a_por : assert property (@(posedge ena_x) disable iff (!pll_lckd)
    core_reset == (lock_edges < POR_CYCLES))
    else report_mismatch("core_reset", 32'(core_reset), 32'(lock_edges < POR_CYCLES));

  // Joystick buses at each load strobe
  a_joy_a : assert property (@(posedge ena_x) disable iff (!pll_lckd)
    !joy_load |-> joy_a == exp1[5:0])
    else report_mismatch("joy_a", 32'(joy_a), 32'(exp1[5:0]));
  a_joy_b : assert property (@(posedge ena_x) disable iff (!pll_lckd)
    !joy_load |-> joy_b == exp2[5:0])
    else report_mismatch("joy_b", 32'(joy_b), 32'(exp2[5:0]));
  a_player : assert property (@(posedge ena_x) disable iff (!pll_lckd)
    !joy_load |-> player_n == {exp2.start_n, exp1.start_n})
    else report_mismatch("player_n", 32'(player_n), 32'({exp2.start_n, exp1.start_n}));
  a_coin : assert property (@(posedge ena_x) disable iff (!pll_lckd)
    !joy_load |-> coin_n == {exp2.coin_n, exp1.coin_n & exp_btn[0]})
    else report_mismatch("coin_n", 32'(coin_n),
                         32'({exp2.coin_n, exp1.coin_n & exp_btn[0]}));

  // Key-driven outputs are not checked while a PS/2 frame is in flight
  a_game_reset : assert property (@(posedge ena_x) disable iff (!pll_lckd)
    !key_busy |-> game_reset == exp_gr)
    else report_mismatch("game_reset", 32'(game_reset), 32'(exp_gr));
  a_reboot : assert property (@(posedge ena_x) disable iff (!pll_lckd)
    !key_busy |-> reboot == exp_reboot)
    else report_mismatch("reboot", 32'(reboot), 32'(exp_reboot));
  a_led0 : assert property (@(posedge ena_x) disable iff (!pll_lckd)
    !key_busy |-> led[0] == exp_mode)
    else report_mismatch("led[0]", 32'(led[0]), 32'(exp_mode));
  a_led1 : assert property (@(posedge ena_x) disable iff (!pll_lckd)
    !key_busy |-> led[1] == (sd2 ^ exp_swap))
    else report_mismatch("led[1]", 32'(led[1]), 32'(sd2 ^ exp_swap));

  a_scandbl : assert property (@(posedge ena_x) disable iff (!pll_lckd)
    scandbl_ctrl == sd1)
    else report_mismatch("scandbl_ctrl", 32'(scandbl_ctrl), 32'(sd1));
  a_sram : assert property (@(posedge ena_x) sram_addr == 19'h08FD5 && sram_we_n)
    else fail_with("SRAM address moved or write enable asserted");

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // One PS/2 frame sent LSB first on a slow keyboard clock
  task automatic send_code(input logic [7:0] code, input logic bad_par);
    logic [10:0] fr;
    fr = {1'b1, (~^code) ^ bad_par, code, 1'b0};
    for (int i = 0; i < 11; i++) begin
      @(posedge ena_x) ps2_data <= fr[i];
      repeat (PS2_HALF / 2) @(posedge ena_x);
      ps2_clk <= 1'b0;
      repeat (PS2_HALF) @(posedge ena_x);
      ps2_clk <= 1'b1;
      repeat (PS2_HALF / 2) @(posedge ena_x);
    end
  endtask

  // Sends a frame and counts the game reset cycles it causes
  // Busy rises in the same step as any new expected mode
  task automatic key_frame(input logic [7:0] code, input logic bad_par, input int want_gr);
    key_busy <= 1'b1;
    send_code(code, bad_par);
    repeat (16) @(posedge ena_x);
    assert (gr_high == want_gr)
      else report_mismatch("game_reset pulse count", 32'(gr_high), 32'(want_gr));
    key_busy <= 1'b0;
    // Settled outputs get one checked cycle before the next frame
    @(posedge ena_x);
  endtask

  task automatic wait_por();
    @(posedge ena_x);
    while (pll_lckd !== 1'b1 || core_reset !== 1'b0)
      @(posedge ena_x);
  endtask

  task automatic wait_loads(input int n);
    int target;
    target = loads + n;
    while (loads < target)
      @(posedge ena_x);
  endtask

  initial begin
    wait_por();
    wait_loads(RAND_FRAMES);
    // Static lines followed by joystick 1 select and button 1
    joy_rand <= 1'b0;
    wait_loads(3);
    fixed_pat <= 24'hDFFFFF;
    wait_loads(2);
    fixed_pat <= '1;
    wait_loads(3);
    fixed_btn <= 2'b01;
    wait_loads(2);
    fixed_btn <= 2'b11;
    wait_loads(3);

    // Mode toggles and codes that must be ignored
    exp_mode = 1'b1;
    key_frame(SC_SCROLL, 1'b0, 0);
    key_frame(SC_BREAK, 1'b0, 0);
    key_frame(SC_SCROLL, 1'b0, 0);
    key_frame(SC_EXTEND, 1'b0, 0);
    key_frame(SC_SCROLL, 1'b0, 0);
    exp_swap = 1'b1;
    key_frame(SC_F3, 1'b0, 0);
    key_frame(SC_F3, 1'b1, 0);
    // Reset key plain and extended
    key_frame(SC_F12, 1'b0, 1);
    key_frame(SC_EXTEND, 1'b0, 0);
    key_frame(SC_F12, 1'b0, 0);
    // Backspace with ctrl alone does nothing while the full chord reboots
    key_frame(SC_CTRL, 1'b0, 0);
    key_frame(SC_BKSP, 1'b0, 0);
    key_frame(SC_ALT, 1'b0, 0);
    chord_sent <= 1'b1;
    key_frame(SC_BKSP, 1'b0, 0);
    repeat (20) @(posedge ena_x);
    chord_sent <= 1'b0;

    // Drop lock again and reboot from joystick 2 select
    @(posedge ena_x) relock_n <= 1'b0;
    exp_mode = 1'b0;
    exp_swap = 1'b0;
    repeat (4) @(posedge ena_x);
    relock_n <= 1'b1;
    wait_por();
    fixed_pat <= 24'hFDFFFF;
    wait_loads(2);
    fixed_pat <= '1;
    wait_loads(3);
    $display("Everything OK");
    $finish;
  end

  // Watchdog sized from the frame counts
  initial begin
    #(WATCH_CYC * 4);
    $display("Timeout, the test sequence did not finish");
    $display("Something failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: tb_clock.sv
/*
  Testbench clock and reset
  Clock with a period of 4, lock held low for 8 cycles
*/
module tb_clock (
  output logic ena_x,
  output logic lock
);

  initial begin
    ena_x = 1'b0;
    forever #2 ena_x = ~ena_x;
  end

  // Lock starts high so that its first fall resets every flop
  initial begin
    lock = 1'b1;
    #1 lock = 1'b0;
    repeat (8) @(posedge ena_x);
    // Release away from the rising edge
    @(negedge ena_x) lock = 1'b1;
  end

endmodule

// File: board_ctrl_top.sv
/*
  Board control top level
  Joystick reader, PS/2 keyboard path and core control wired to pins
*/
module board_ctrl_top (
  input  logic        ena_x,
  input  logic        pll_lckd,
  input  logic        joy_data,
  input  logic        ps2_clk,
  input  logic        ps2_data,
  input  logic [1:0]  btn,
  input  logic [7:0]  sram_data,
  output logic        joy_load,
  output logic [18:0] sram_addr,
  output logic        sram_we_n,
  output logic [1:0]  led,
  output logic        core_reset,
  output logic        game_reset,
  output logic        reboot,
  output logic [5:0]  joy_a,
  output logic [5:0]  joy_b,
  output logic [1:0]  player_n,
  output logic [1:0]  coin_n,
  output logic [1:0]  scandbl_ctrl
);
  import board_pkg::*;

  joy_state_t joy1;
  joy_state_t joy2;
  key_flags_t keys;
  logic [7:0] scan_code;
  logic       code_valid;

  // SRAM is only read, at the scan-doubler register
  assign sram_addr = SCANDBL_ADDR;
  assign sram_we_n = 1'b1;

  joy_serial_reader u_joy (
    .ena_x    (ena_x),
    .pll_lckd (pll_lckd),
    .joy_data (joy_data),
    .joy_load (joy_load),
    .joy1     (joy1),
    .joy2     (joy2)
  );

  ps2_receiver u_ps2 (
    .ena_x      (ena_x),
    .pll_lckd   (pll_lckd),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .scan_code  (scan_code),
    .code_valid (code_valid)
  );

  key_decoder u_keys (
    .ena_x      (ena_x),
    .pll_lckd   (pll_lckd),
    .scan_code  (scan_code),
    .code_valid (code_valid),
    .keys       (keys)
  );

  core_control u_ctrl (
    .ena_x        (ena_x),
    .pll_lckd     (pll_lckd),
    .joy1         (joy1),
    .joy2         (joy2),
    .keys         (keys),
    .btn          (btn),
    .sram_data    (sram_data),
    .core_reset   (core_reset),
    .game_reset   (game_reset),
    .reboot       (reboot),
    .joy_a        (joy_a),
    .joy_b        (joy_b),
    .player_n     (player_n),
    .coin_n       (coin_n),
    .scandbl_ctrl (scandbl_ctrl),
    .led          (led)
  );

endmodule

// File: core_control.sv
/*
  Game core control
  Power-on reset delay, game reset and sticky reboot, coin and start
  mapping, scan-doubler register and board LEDs
*/
module core_control (
  input  logic                  ena_x,
  input  logic                  pll_lckd,
  input  board_pkg::joy_state_t joy1,
  input  board_pkg::joy_state_t joy2,
  input  board_pkg::key_flags_t keys,
  input  logic [1:0]            btn,
  input  logic [7:0]            sram_data,
  output logic                  core_reset,
  output logic                  game_reset,
  output logic                  reboot,
  output logic [5:0]            joy_a,
  output logic [5:0]            joy_b,
  output logic [1:0]            player_n,
  output logic [1:0]            coin_n,
  output logic [1:0]            scandbl_ctrl,
  output logic [1:0]            led
);
  import board_pkg::*;

  logic [POR_CNT_W-1:0] por_cnt;

  //////////////////////////////////////////////////////////////////////
  // Power-on hold, resets and controls
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      por_cnt      <= '0;
      core_reset   <= 1'b1;
      game_reset   <= 1'b0;
      reboot       <= 1'b0;
      player_n     <= 2'b11;
      coin_n       <= 2'b11;
      scandbl_ctrl <= 2'b00;
      led          <= 2'b00;
    end else begin
      // Core released on the last count, counter then parks
      if (core_reset) begin
        por_cnt <= por_cnt + 1'b1;
        if (por_cnt == POR_LAST)
          core_reset <= 1'b0;
      end
      // F12, joystick 1 select or board button 1
      game_reset <= keys.reset_key | ~joy1.sel_n | ~btn[1];
      // Reboot request holds until the clock unlocks
      if (keys.master_key || !joy2.sel_n)
        reboot <= 1'b1;
      player_n <= {joy2.start_n, joy1.start_n};
      // Board button 0 doubles as coin 1
      coin_n   <= {joy2.coin_n, joy1.coin_n & btn[0]};
      scandbl_ctrl <= sram_data[1:0];
      led[0] <= keys.key_mode;
      led[1] <= scandbl_ctrl[0] ^ keys.video_swap;
    end
  end

  // Fire and direction group to the core
  assign joy_a = {joy1.fire2_n, joy1.fire1_n, joy1.right_n,
                  joy1.left_n, joy1.down_n, joy1.up_n};
  assign joy_b = {joy2.fire2_n, joy2.fire1_n, joy2.right_n,
                  joy2.left_n, joy2.down_n, joy2.up_n};

  // Reboot stays asserted for as long as the clock stays locked
  a_reboot_sticky : assert property (@(posedge ena_x) disable iff (!pll_lckd)
    reboot |=> reboot);

endmodule

// File: key_decoder.sv
/*
  Control key decoder
  Follows break and extend prefixes and the ctrl and alt state,
  toggles the mode flags and pulses the reset and master keys
*/
module key_decoder (
  input  logic                  ena_x,
  input  logic                  pll_lckd,
  input  logic [7:0]            scan_code,
  input  logic                  code_valid,
  output board_pkg::key_flags_t keys
);
  import board_pkg::*;

  logic brk_q;
  logic ext_q;
  logic ctrl_q;
  logic alt_q;
  logic key_mode_q;
  logic video_swap_q;
  logic reset_key_q;
  logic master_key_q;

  //////////////////////////////////////////////////////////////////////
  // Prefix tracking and key actions
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      brk_q        <= 1'b0;
      ext_q        <= 1'b0;
      ctrl_q       <= 1'b0;
      alt_q        <= 1'b0;
      key_mode_q   <= 1'b0;
      video_swap_q <= 1'b0;
      reset_key_q  <= 1'b0;
      master_key_q <= 1'b0;
    end else begin
      // Pulses last one cycle
      reset_key_q  <= 1'b0;
      master_key_q <= 1'b0;
      if (code_valid) begin
        if (scan_code == SC_BREAK) begin
          brk_q <= 1'b1;
        end else if (scan_code == SC_EXTEND) begin
          ext_q <= 1'b1;
        end else begin
          // Any other byte ends the prefix sequence
          brk_q <= 1'b0;
          ext_q <= 1'b0;
          if (ext_q) begin
            // Extended keys are other keys, nothing to do
          end else if (brk_q) begin
            // Releases only matter for the modifiers
            if (scan_code == SC_CTRL)
              ctrl_q <= 1'b0;
            if (scan_code == SC_ALT)
              alt_q <= 1'b0;
          end else begin
            case (scan_code)
              SC_SCROLL: key_mode_q   <= ~key_mode_q;
              SC_F3:     video_swap_q <= ~video_swap_q;
              SC_F12:    reset_key_q  <= 1'b1;
              SC_CTRL:   ctrl_q       <= 1'b1;
              SC_ALT:    alt_q        <= 1'b1;
              // Master chord needs both modifiers held
              SC_BKSP:   master_key_q <= ctrl_q & alt_q;
              default:   ;
            endcase
          end
        end
      end
    end
  end

  always_comb begin
    keys.key_mode   = key_mode_q;
    keys.video_swap = video_swap_q;
    keys.reset_key  = reset_key_q;
    keys.master_key = master_key_q;
  end

  // Key pulses never stretch
  a_reset_pulse : assert property (@(posedge ena_x) disable iff (!pll_lckd)
    keys.reset_key |=> !keys.reset_key);
  a_master_pulse : assert property (@(posedge ena_x) disable iff (!pll_lckd)
    keys.master_key |=> !keys.master_key);

endmodule

// File: ps2_receiver.sv
/*
  PS/2 keyboard receiver
  Synchronizes the PS/2 lines, shifts 11-bit frames on the falling
  clock edge and emits checked scan-code bytes with a strobe
*/
module ps2_receiver (
  input  logic       ena_x,
  input  logic       pll_lckd,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic [7:0] scan_code,
  output logic       code_valid
);
  import board_pkg::*;

  logic [1:0]                clk_sync;
  logic [1:0]                data_sync;
  logic                      clk_prev;
  logic                      ps2_fall;
  logic [PS2_FRAME_BITS-1:0] frame;
  logic [PS2_FRAME_BITS-1:0] frame_next;
  logic                      frame_ok;
  logic [PS2_BIT_W-1:0]      bit_cnt;
  logic [PS2_IDLE_W-1:0]     idle_cnt;

  //////////////////////////////////////////////////////////////////////
  // Line synchronizer and edge detect
  //////////////////////////////////////////////////////////////////////

  // Idle PS/2 lines are high
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      clk_sync  <= 2'b11;
      data_sync <= 2'b11;
      clk_prev  <= 1'b1;
    end else begin
      clk_sync  <= {clk_sync[0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
      clk_prev  <= clk_sync[1];
    end
  end

  assign ps2_fall = clk_prev & ~clk_sync[1];

  // LSB first, so new bits enter at the top
  assign frame_next = {data_sync[1], frame[PS2_FRAME_BITS-1:1]};

  // Start low, stop high, odd parity over data and parity bit
  assign frame_ok = ~frame_next[0] & frame_next[PS2_FRAME_BITS-1] & (^frame_next[9:1]);

  //////////////////////////////////////////////////////////////////////
  // Bit counter, idle timeout, strobe
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      bit_cnt    <= '0;
      idle_cnt   <= '0;
      code_valid <= 1'b0;
    end else begin
      code_valid <= 1'b0;
      if (ps2_fall) begin
        idle_cnt <= '0;
        if (bit_cnt == PS2_LAST_BIT) begin
          bit_cnt    <= '0;
          code_valid <= frame_ok;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else if (idle_cnt != PS2_IDLE_LAST) begin
        idle_cnt <= idle_cnt + 1'b1;
      end else begin
        // Keyboard went quiet mid-frame, start over
        bit_cnt <= '0;
      end
    end
  end

  // Frame shifter and output byte
  always_ff @(posedge ena_x) begin
    if (ps2_fall)
      frame <= frame_next;
    if (ps2_fall && bit_cnt == PS2_LAST_BIT)
      scan_code <= frame_next[8:1];
  end

  // Strobe is a single-cycle pulse
  a_valid_pulse : assert property (@(posedge ena_x) disable iff (!pll_lckd)
    code_valid |=> !code_valid);

endmodule

// File: joy_serial_reader.sv
/*
  Dual joystick reader
  Drives the load strobe of the external shift register, samples
  24 serial bits per frame and publishes both joysticks at frame end
*/
module joy_serial_reader (
  input  logic                  ena_x,
  input  logic                  pll_lckd,
  input  logic                  joy_data,
  output logic                  joy_load,
  output board_pkg::joy_state_t joy1,
  output board_pkg::joy_state_t joy2
);
  import board_pkg::*;

  logic [JOY_CNT_W-1:0]    cnt;
  logic                    frame_done;
  logic [JOY_SHADOW_W-1:0] shadow;

  //////////////////////////////////////////////////////////////////////
  // Frame counter and load strobe
  //////////////////////////////////////////////////////////////////////

  // Load goes low for count 0 only
  // The register looks one count ahead so the pin is glitch free
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      cnt        <= '0;
      joy_load   <= 1'b1;
      frame_done <= 1'b0;
    end else begin
      joy_load   <= (cnt != JOY_LAST);
      frame_done <= (cnt == JOY_LAST);
      if (cnt == JOY_LAST)
        cnt <= '0;
      else
        cnt <= cnt + 1'b1;
    end
  end

  // Serial bits land in the shadow, index is count minus first bit
  always_ff @(posedge ena_x) begin
    if (cnt >= JOY_CNT_W'(JOY_FIRST_BIT))
      shadow[JOY_CNT_W'(cnt - JOY_CNT_W'(JOY_FIRST_BIT))] <= joy_data;
  end

  //////////////////////////////////////////////////////////////////////
  // Publish both joysticks in one edge
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      joy1 <= '1;
      joy2 <= '1;
    end else if (frame_done) begin
      // First eight bits: joystick 1 start, fires, directions
      joy1.start_n <= shadow[0];
      joy1.fire3_n <= shadow[1];
      joy1.fire2_n <= shadow[2];
      joy1.fire1_n <= shadow[3];
      joy1.right_n <= shadow[4];
      joy1.left_n  <= shadow[5];
      joy1.down_n  <= shadow[6];
      joy1.up_n    <= shadow[7];
      // Same group for joystick 2
      joy2.start_n <= shadow[8];
      joy2.fire3_n <= shadow[9];
      joy2.fire2_n <= shadow[10];
      joy2.fire1_n <= shadow[11];
      joy2.right_n <= shadow[12];
      joy2.left_n  <= shadow[13];
      joy2.down_n  <= shadow[14];
      joy2.up_n    <= shadow[15];
      // Extra buttons, joystick 2 comes before joystick 1
      joy2.aux_n   <= shadow[16];
      joy2.sel_n   <= shadow[17];
      joy2.coin_n  <= shadow[18];
      joy2.aux2_n  <= shadow[19];
      joy1.aux_n   <= shadow[20];
      joy1.sel_n   <= shadow[21];
      joy1.coin_n  <= shadow[22];
      joy1.aux2_n  <= shadow[23];
    end
  end

  // Counter stays inside the frame
  a_cnt_range : assert property (@(posedge ena_x) disable iff (!pll_lckd)
    cnt <= JOY_LAST);

endmodule

// File: board_pkg.sv
/*
  Board control package
  Joystick and key flag structs, frame and timing constants,
  PS/2 scan codes and the SRAM location of the scan-doubler register
*/
package board_pkg;

  //////////////////////////////////////////////////////////////////////
  // Shared types
  //////////////////////////////////////////////////////////////////////

  // One joystick, every line active low
  // Low six fields go straight to the game core
  typedef struct packed {
    logic sel_n;
    logic aux_n;
    logic coin_n;
    logic start_n;
    logic aux2_n;
    logic fire3_n;
    logic fire2_n;
    logic fire1_n;
    logic right_n;
    logic left_n;
    logic down_n;
    logic up_n;
  } joy_state_t;

  // Toggled modes first, then the one-cycle key pulses
  typedef struct packed {
    logic key_mode;
    logic video_swap;
    logic reset_key;
    logic master_key;
  } key_flags_t;

  //////////////////////////////////////////////////////////////////////
  // Joystick frame
  //////////////////////////////////////////////////////////////////////

  localparam int JOY_FRAME_LEN = 26;
  localparam int JOY_FIRST_BIT = 2;
  localparam int JOY_CNT_W     = 5;
  localparam int JOY_SHADOW_W  = JOY_FRAME_LEN - JOY_FIRST_BIT;
  localparam logic [JOY_CNT_W-1:0] JOY_LAST = JOY_CNT_W'(JOY_FRAME_LEN - 1);

  // Power-on hold of the game core after clock lock
  localparam int POR_CYCLES = 256;
  localparam int POR_CNT_W  = 8;
  localparam logic [POR_CNT_W-1:0] POR_LAST = POR_CNT_W'(POR_CYCLES - 1);

  // PS/2 framing: start, 8 data, odd parity, stop
  localparam int PS2_FRAME_BITS  = 11;
  localparam int PS2_BIT_W       = 4;
  localparam logic [PS2_BIT_W-1:0] PS2_LAST_BIT = PS2_BIT_W'(PS2_FRAME_BITS - 1);
  localparam int PS2_IDLE_CYCLES = 2048;
  localparam int PS2_IDLE_W      = 11;
  localparam logic [PS2_IDLE_W-1:0] PS2_IDLE_LAST = PS2_IDLE_W'(PS2_IDLE_CYCLES - 1);

  //////////////////////////////////////////////////////////////////////
  // Scan codes, set 2
  //////////////////////////////////////////////////////////////////////

  localparam logic [7:0] SC_BREAK  = 8'hF0;
  localparam logic [7:0] SC_EXTEND = 8'hE0;
  localparam logic [7:0] SC_SCROLL = 8'h7E;
  localparam logic [7:0] SC_F3     = 8'h04;
  localparam logic [7:0] SC_F12    = 8'h07;
  localparam logic [7:0] SC_CTRL   = 8'h14;
  localparam logic [7:0] SC_ALT    = 8'h11;
  localparam logic [7:0] SC_BKSP   = 8'h66;

  // Scan-doubler control register in external SRAM
  localparam logic [18:0] SCANDBL_ADDR = 19'h08FD5;

endpackage
